//--- dcache_top.f
verilog/dcache_pkg.sv
verilog/dcache_ctrl.sv
verilog/dcache_tag_store.sv
verilog/dcache_data_store.sv
verilog/dcache_top.sv
test/dcache_tb_mem.sv
test/dcache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the dcache testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module dcache_tb \
    -f dcache_top.f \
    -o dcache_sim

./obj_dir/dcache_sim | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- test/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  cpu_rreq;
    logic                  cpu_wreq;
    logic [ADDR_W-1:0]     vaddr;
    logic [WORD_W-1:0]     cpu_wdata;
    logic [BYTE_SEL_W-1:0] cpu_wsel;
    logic                  hit;
    logic                  data_valid;
    logic [WORD_W-1:0]     cpu_data;
    logic                  stall;
    logic                  mem_rvalid;
    logic [LINE_W-1:0]     mem_rdata;
    logic                  mem_bvalid;
    logic                  mem_ren;
    logic [ADDR_W-1:0]     araddr;
    logic                  mem_wen;
    logic [LINE_W-1:0]     mem_wdata;
    logic [ADDR_W-1:0]     awaddr;
    logic [ADDR_W-1:0]     peek_addr;
    logic [LINE_W-1:0]     peek_line;

    // main process state
    int                errors = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    int                reads_issued = 0;
    int                last_wait = 0;
    bit                timed_out = 1'b0;
    bit                last_hit = 1'b0;
    logic [WORD_W-1:0] exp_word = '0;
    logic [WORD_W-1:0] shadow [logic [ADDR_W-1:0]];

    // monitor state
    int                mon_errors = 0;
    int                valids_seen = 0;
    int                rd_cnt = 0;
    int                wr_cnt = 0;
    logic [ADDR_W-1:0] last_araddr = '0;
    logic [ADDR_W-1:0] last_awaddr = '0;
    bit                evicted [logic [ADDR_W-1:0]];

    always #10 clk = ~clk;

    dcache_top UUT (
        .clk              (clk),
        .rst              (rst),
        .cpu_rreq_i       (cpu_rreq),
        .cpu_wreq_i       (cpu_wreq),
        .virtual_addr_i   (vaddr),
        .cpu_wdata_i      (cpu_wdata),
        .cpu_wsel_i       (cpu_wsel),
        .hit_o            (hit),
        .cpu_data_valid_o (data_valid),
        .cpu_data_o       (cpu_data),
        .cpu_stall_o      (stall),
        .mem_rvalid_i     (mem_rvalid),
        .mem_rdata_i      (mem_rdata),
        .mem_bvalid_i     (mem_bvalid),
        .mem_ren_o        (mem_ren),
        .mem_araddr_o     (araddr),
        .mem_wen_o        (mem_wen),
        .mem_wdata_o      (mem_wdata),
        .mem_awaddr_o     (awaddr)
    );

    dcache_tb_mem mem_model (
        .clk          (clk),
        .rst          (rst),
        .mem_ren_i    (mem_ren),
        .mem_araddr_i (araddr),
        .mem_wen_i    (mem_wen),
        .mem_awaddr_i (awaddr),
        .mem_wdata_i  (mem_wdata),
        .peek_addr_i  (peek_addr),
        .mem_rvalid_o (mem_rvalid),
        .mem_rdata_o  (mem_rdata),
        .mem_bvalid_o (mem_bvalid),
        .peek_line_o  (peek_line)
    );

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // same content the memory holds before any write
    function automatic logic [WORD_W-1:0] init_word(input logic [ADDR_W-1:0] addr);
        return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [WORD_W-1:0] ref_word(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] key;
        key = {addr[ADDR_W-1:2], 2'b00};
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return init_word(key);
    endfunction

    function automatic logic [LINE_W-1:0] ref_line(input logic [ADDR_W-1:0] base);
        logic [LINE_W-1:0] line;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            line[WORD_W*i +: WORD_W] = ref_word(base + ADDR_W'(4*i));
        end
        return line;
    endfunction

    function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
                                                    input logic [INDEX_W-1:0] index,
                                                    input logic [OFFSET_W-1:0] word);
        return {tag, index, word, 2'b00};
    endfunction

    task automatic shadow_write(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data,
                                input logic [BYTE_SEL_W-1:0] sel);
        logic [WORD_W-1:0] word;
        word = ref_word(addr);
        for (int k = 0; k < BYTE_SEL_W; k++) begin
            if (sel[k]) begin
                word[8*k +: 8] = data[8*k +: 8];
            end
        end
        shadow[{addr[ADDR_W-1:2], 2'b00}] = word;
    endtask

    ////////////////////////////////////////
    // checker and memory monitor
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst && data_valid) begin
            if (valids_seen == reads_issued) begin
                $display("data valid strobe without a pending read at %0t", $time);
                mon_errors++;
            end else begin
                valids_seen++;
                if (cpu_data !== exp_word) begin
                    $display("[ERROR] cpu_data_o: got %h, expected %h", cpu_data, exp_word);
                    mon_errors++;
                end
            end
        end
        if (!rst && mem_ren && mem_rvalid) begin
            rd_cnt++;
            last_araddr = araddr;
            evicted.delete(araddr);
        end
        if (!rst && mem_wen && mem_bvalid) begin
            wr_cnt++;
            last_awaddr = awaddr;
            evicted[awaddr] = 1'b1;
            // the victim must hold every write made to it
            if (mem_wdata !== ref_line(awaddr)) begin
                $display("[ERROR] mem_wdata_o: got %h, expected %h", mem_wdata, ref_line(awaddr));
                mon_errors++;
            end
        end
    end

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    function automatic int total_errors();
        return errors + mon_errors;
    endfunction

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic access(input bit is_write, input logic [ADDR_W-1:0] addr,
                          input logic [WORD_W-1:0] data, input logic [BYTE_SEL_W-1:0] sel);
        int waited;
        if (timed_out) begin
            return;
        end
        @(negedge clk);
        cpu_rreq  = !is_write;
        cpu_wreq  = is_write;
        vaddr     = addr;
        cpu_wdata = data;
        cpu_wsel  = sel;
        if (is_write) begin
            shadow_write(addr, data, sel);
        end else begin
            exp_word = ref_word(addr);
            reads_issued++;
        end
        @(negedge clk);
        cpu_rreq = 1'b0;
        cpu_wreq = 1'b0;
        @(posedge clk);
        last_hit = hit;
        waited   = 0;
        while (stall && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        last_wait = waited;
        if (stall) begin
            $display("timeout: stall stayed high after the request to %h", addr);
            errors++;
            timed_out = 1'b1;
            return;
        end
        @(negedge clk);
        if (valids_seen != reads_issued) begin
            $display("read of %h finished without a data valid strobe", addr);
            errors++;
        end
    endtask

    task automatic check_mem_line(input logic [ADDR_W-1:0] base);
        peek_addr = base;
        repeat (2) @(negedge clk);
        if (peek_line !== ref_line(base)) begin
            $display("[ERROR] memory line %h: got %h, expected %h", base, peek_line,
                     ref_line(base));
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int mark);
        tests_run++;
        if (total_errors() == mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     total_errors() - mark);
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        int                mark;
        int                r0;
        int                w0;
        logic [ADDR_W-1:0] a;
        void'($urandom(32'h465972c5));
        rst       = 1'b1;
        cpu_rreq  = 1'b0;
        cpu_wreq  = 1'b0;
        vaddr     = '0;
        cpu_wdata = '0;
        cpu_wsel  = '0;
        peek_addr = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        mark = total_errors();
        @(negedge clk);
        expect_value("cpu_stall_o", 32'(stall), 32'd0);
        expect_value("hit_o", 32'(hit), 32'd0);
        expect_value("cpu_data_valid_o", 32'(data_valid), 32'd0);
        expect_value("mem_ren_o", 32'(mem_ren), 32'd0);
        expect_value("mem_wen_o", 32'(mem_wen), 32'd0);
        end_test("idle after reset", mark);

        mark = total_errors();
        r0   = rd_cnt;
        a    = make_addr(20'h00012, 7'd3, 3'd5);
        access(1'b0, a, '0, '0);
        expect_value("mem read count", rd_cnt, r0 + 1);
        expect_value("mem_araddr_o", last_araddr, {a[ADDR_W-1:5], 5'b0});
        access(1'b0, make_addr(20'h00012, 7'd3, 3'd2), '0, '0);
        expect_value("hit_o", 32'(last_hit), 32'd1);
        expect_value("hit wait cycles", last_wait, 32'd0);
        end_test("read miss then read hit", mark);

        mark = total_errors();
        r0   = rd_cnt;
        w0   = wr_cnt;
        access(1'b1, a, 32'hdead_beef, 4'b0110);
        expect_value("hit_o", 32'(last_hit), 32'd1);
        access(1'b0, a, '0, '0);
        expect_value("hit_o", 32'(last_hit), 32'd1);
        expect_value("mem read count", rd_cnt, r0);
        expect_value("mem write count", wr_cnt, w0);
        end_test("partial write hit", mark);

        mark = total_errors();
        r0   = rd_cnt;
        a    = make_addr(20'h00034, 7'd9, 3'd1);
        access(1'b1, a, 32'h1234_5678, 4'b1001);
        expect_value("hit_o", 32'(last_hit), 32'd0);
        expect_value("mem read count", rd_cnt, r0 + 1);
        access(1'b0, a, '0, '0);
        expect_value("hit_o", 32'(last_hit), 32'd1);
        end_test("write miss allocate", mark);

        // third tag in one set pushes out the oldest dirty line
        mark = total_errors();
        w0   = wr_cnt;
        a    = make_addr(20'h00100, 7'd20, 3'd0);
        access(1'b1, a, 32'haaaa_0001, 4'b1111);
        access(1'b1, make_addr(20'h00200, 7'd20, 3'd0), 32'hbbbb_0002, 4'b1111);
        expect_value("mem write count", wr_cnt, w0);
        access(1'b1, make_addr(20'h00300, 7'd20, 3'd0), 32'hcccc_0003, 4'b1111);
        expect_value("mem write count", wr_cnt, w0 + 1);
        expect_value("mem_awaddr_o", last_awaddr, a);
        check_mem_line(a);
        end_test("dirty eviction", mark);

        mark = total_errors();
        for (int i = 0; i < 200; i++) begin
            a = make_addr(20'h00a00 + 20'($urandom_range(3, 0)),
                          7'd40 + 7'($urandom_range(3, 0)), 3'($urandom_range(7, 0)));
            if ($urandom_range(1, 0) == 1) begin
                access(1'b1, a, $urandom, 4'($urandom_range(15, 1)));
            end else begin
                access(1'b0, a, '0, '0);
            end
        end
        foreach (evicted[e]) begin
            check_mem_line(e);
        end
        end_test("random mix", mark);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- test/dcache_tb_mem.sv
`timescale 1ns/1ps

module dcache_tb_mem
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_ren_i,
    input  logic [ADDR_W-1:0] mem_araddr_i,
    input  logic              mem_wen_i,
    input  logic [ADDR_W-1:0] mem_awaddr_i,
    input  logic [LINE_W-1:0] mem_wdata_i,
    input  logic [ADDR_W-1:0] peek_addr_i,
    output logic              mem_rvalid_o,
    output logic [LINE_W-1:0] mem_rdata_o,
    output logic              mem_bvalid_o,
    output logic [LINE_W-1:0] peek_line_o
);

    // only lines that were written back are stored
    logic [LINE_W-1:0] lines [logic [ADDR_W-1:0]];
    logic              busy;
    int                delay;

    // untouched memory content mixing every address bit
    function automatic logic [WORD_W-1:0] init_word(input logic [ADDR_W-1:0] addr);
        return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [ADDR_W-1:0] line_base(input logic [ADDR_W-1:0] addr);
        return {addr[ADDR_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
    endfunction

    function automatic logic [LINE_W-1:0] read_line(input logic [ADDR_W-1:0] base);
        logic [LINE_W-1:0] line;
        if (lines.exists(base)) begin
            return lines[base];
        end
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            line[WORD_W*i +: WORD_W] = init_word(base + ADDR_W'(4*i));
        end
        return line;
    endfunction

    ////////////////////////////////////////
    // one strobe handled at a time
    ////////////////////////////////////////

    initial begin
        mem_rvalid_o = 1'b0;
        mem_bvalid_o = 1'b0;
        mem_rdata_o  = '0;
        peek_line_o  = '0;
        busy         = 1'b0;
        delay        = 0;
        forever begin
            @(negedge clk);
            mem_rvalid_o = 1'b0;
            mem_bvalid_o = 1'b0;
            if (rst) begin
                busy = 1'b0;
            end else if (busy) begin
                if (delay == 0) begin
                    busy = 1'b0;
                    if (mem_wen_i) begin
                        lines[line_base(mem_awaddr_i)] = mem_wdata_i;
                        mem_bvalid_o = 1'b1;
                    end else begin
                        mem_rdata_o  = read_line(line_base(mem_araddr_i));
                        mem_rvalid_o = 1'b1;
                    end
                end else begin
                    delay = delay - 1;
                end
            end else if (mem_ren_i || mem_wen_i) begin
                // answer after 1 to 4 cycles
                busy  = 1'b1;
                delay = $urandom_range(3, 0);
            end
            peek_line_o = read_line(line_base(peek_addr_i));
        end
    end

endmodule

//--- verilog/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_rreq_i,
    input  logic                  cpu_wreq_i,
    input  logic [ADDR_W-1:0]     virtual_addr_i,
    input  logic [WORD_W-1:0]     cpu_wdata_i,
    input  logic [BYTE_SEL_W-1:0] cpu_wsel_i,
    input  logic                  mem_rvalid_i,
    input  logic                  mem_bvalid_i,
    input  logic [NUM_WAYS-1:0]   hit_way_i,
    input  logic                  victim_way_i,
    input  logic                  victim_dirty_i,
    input  logic [TAG_W-1:0]      victim_tag_i,
    output logic [INDEX_W-1:0]    index_o,
    output logic [TAG_W-1:0]      tag_o,
    output logic [OFFSET_W-1:0]   word_sel_o,
    output logic [WORD_W-1:0]     wdata_o,
    output logic [BYTE_SEL_W-1:0] wsel_o,
    output logic                  rd_way_o,
    output logic                  hit_write_o,
    output logic                  lru_touch_o,
    output logic                  fill_en_o,
    output logic                  fill_way_o,
    output logic                  fill_dirty_o,
    output logic                  hit_o,
    output logic                  cpu_data_valid_o,
    output logic                  cpu_stall_o,
    output logic                  mem_ren_o,
    output logic [ADDR_W-1:0]     mem_araddr_o,
    output logic                  mem_wen_o,
    output logic [ADDR_W-1:0]     mem_awaddr_o
);

    cache_state_e          state;
    cache_state_e          next_state;
    cpu_op_e               op_q;
    logic [ADDR_W-1:0]     addr_q;
    logic [WORD_W-1:0]     wdata_q;
    logic [BYTE_SEL_W-1:0] wsel_q;
    logic                  cpu_req;
    logic                  any_hit;
    logic [INDEX_W-1:0]    index_q;

    assign cpu_req = cpu_rreq_i | cpu_wreq_i;
    assign any_hit = |hit_way_i;
    assign index_q = addr_q[INDEX_LSB +: INDEX_W];

    ////////////////////////////////////////
    // request latch
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == ST_LOOKUP && cpu_req) begin
            addr_q  <= virtual_addr_i;
            wdata_q <= cpu_wdata_i;
            wsel_q  <= cpu_wsel_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q <= OP_READ;
        end else if (state == ST_LOOKUP && cpu_req) begin
            op_q <= cpu_wreq_i ? OP_WRITE : OP_READ;
        end
    end

    // incoming index in lookup so the stores answer in compare
    assign index_o    = (state == ST_LOOKUP) ? virtual_addr_i[INDEX_LSB +: INDEX_W] : index_q;
    assign tag_o      = addr_q[TAG_LSB +: TAG_W];
    assign word_sel_o = addr_q[OFFSET_LSB +: OFFSET_W];
    assign wdata_o    = wdata_q;
    assign wsel_o     = wsel_q;

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_LOOKUP;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_LOOKUP: begin
                if (cpu_req) begin
                    next_state = ST_COMPARE;
                end
            end
            ST_COMPARE: begin
                if (any_hit) begin
                    next_state = ST_LOOKUP;
                end else if (victim_dirty_i) begin
                    next_state = ST_WRITEBACK;
                end else begin
                    next_state = ST_REFILL;
                end
            end
            // victim info holds as the set is reread every cycle
            ST_WRITEBACK: begin
                if (mem_bvalid_i) begin
                    next_state = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (mem_rvalid_i) begin
                    next_state = ST_LOOKUP;
                end
            end
            default: next_state = ST_LOOKUP;
        endcase
    end

    ////////////////////////////////////////
    // store controls and cpu strobes
    ////////////////////////////////////////

    assign hit_o        = (state == ST_COMPARE) && any_hit;
    assign rd_way_o     = hit_way_i[1];
    assign hit_write_o  = hit_o && (op_q == OP_WRITE);
    assign lru_touch_o  = hit_o;
    assign fill_en_o    = (state == ST_REFILL) && mem_rvalid_i;
    assign fill_way_o   = victim_way_i;
    assign fill_dirty_o = (op_q == OP_WRITE);

    // refill word goes straight to the cpu in the rvalid cycle
    assign cpu_data_valid_o = (op_q == OP_READ) && (hit_o || fill_en_o);

    assign cpu_stall_o = ((state == ST_LOOKUP) && cpu_req)
                       || ((state == ST_COMPARE) && !any_hit)
                       || (state == ST_WRITEBACK)
                       || ((state == ST_REFILL) && !mem_rvalid_i);

    // memory strobes are levels held until the response
    assign mem_ren_o    = (state == ST_REFILL);
    assign mem_wen_o    = (state == ST_WRITEBACK);
    assign mem_araddr_o = {tag_o, index_q, {INDEX_LSB{1'b0}}};
    assign mem_awaddr_o = {victim_tag_i, index_q, {INDEX_LSB{1'b0}}};

    // a dirty victim never holds the line that is about to be refilled
    a_wb_other_line: assert property (@(posedge clk) disable iff (rst)
        mem_wen_o |-> (mem_awaddr_o != mem_araddr_o));

    // the cpu only asks while the cache is idle
    a_req_in_lookup: assert property (@(posedge clk) disable iff (rst)
        cpu_req |-> (state == ST_LOOKUP));

endmodule

//--- verilog/dcache_data_store.sv
`timescale 1ns/1ps

module dcache_data_store
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic [INDEX_W-1:0]    index_i,
    input  logic [OFFSET_W-1:0]   word_sel_i,
    input  logic                  rd_way_i,
    input  logic                  hit_write_i,
    input  logic [BYTE_SEL_W-1:0] wsel_i,
    input  logic [WORD_W-1:0]     wdata_i,
    input  logic                  fill_en_i,
    input  logic                  fill_way_i,
    input  logic                  fill_merge_i,
    input  logic [LINE_W-1:0]     fill_line_i,
    input  logic                  victim_way_i,
    output logic [WORD_W-1:0]     rdata_word_o,
    output logic [LINE_W-1:0]     victim_line_o
);

    logic [WORD_W-1:0] byte_mask;
    logic [LINE_W-1:0] merged_line;
    logic [WORD_W-1:0] hit_word;
    wire  [LINE_W-1:0] way_line [NUM_WAYS];

    ////////////////////////////////////////
    // write-miss merge
    ////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < BYTE_SEL_W; k++) begin
            byte_mask[BYTE_W*k +: BYTE_W] = {BYTE_W{wsel_i[k]}};
        end
    end

    // selected bytes from the cpu, the rest from memory
    always_comb begin
        merged_line = fill_line_i;
        if (fill_merge_i) begin
            merged_line[WORD_W*word_sel_i +: WORD_W] =
                (wdata_i & byte_mask)
                | (fill_line_i[WORD_W*word_sel_i +: WORD_W] & ~byte_mask);
        end
    end

    ////////////////////////////////////////
    // word banks
    ////////////////////////////////////////

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        for (genvar b = 0; b < WORDS_PER_LINE; b++) begin : g_bank
            logic [WORD_W-1:0]     mem [NUM_SETS];
            logic [WORD_W-1:0]     rd_q;
            logic [WORD_W-1:0]     wr_word;
            logic [BYTE_SEL_W-1:0] wr_be;
            logic                  fill_we;
            logic                  hit_we;

            assign fill_we = fill_en_i && (fill_way_i == 1'(w));
            assign hit_we  = hit_write_i && (rd_way_i == 1'(w))
                           && (word_sel_i == OFFSET_W'(b));

            // full word on a fill, cpu bytes on a write hit
            assign wr_word = fill_we ? merged_line[WORD_W*b +: WORD_W] : wdata_i;
            assign wr_be   = fill_we ? {BYTE_SEL_W{1'b1}}
                           : (hit_we ? wsel_i : {BYTE_SEL_W{1'b0}});

            always_ff @(posedge clk) begin
                for (int k = 0; k < BYTE_SEL_W; k++) begin
                    if (wr_be[k]) begin
                        mem[index_i][BYTE_W*k +: BYTE_W] <= wr_word[BYTE_W*k +: BYTE_W];
                    end
                end
                rd_q <= mem[index_i];
            end

            assign way_line[w][WORD_W*b +: WORD_W] = rd_q;
        end
    end

    ////////////////////////////////////////
    // read select
    ////////////////////////////////////////

    assign hit_word      = way_line[rd_way_i][WORD_W*word_sel_i +: WORD_W];
    // the merged refill word bypasses the banks written at this edge
    assign rdata_word_o  = fill_en_i ? merged_line[WORD_W*word_sel_i +: WORD_W] : hit_word;
    assign victim_line_o = way_line[victim_way_i];

endmodule

//--- verilog/dcache_pkg.sv
package dcache_pkg;

    ////////////////////////////////////////
    // address and data widths
    ////////////////////////////////////////

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int BYTE_W     = 8;
    localparam int BYTE_SEL_W = WORD_W / BYTE_W;

    // address fields from the top are tag, index, word offset and byte offset
    localparam int TAG_W      = 20;
    localparam int TAG_LSB    = 12;
    localparam int INDEX_W    = 7;
    localparam int INDEX_LSB  = 5;
    localparam int OFFSET_W   = 3;
    localparam int OFFSET_LSB = 2;

    ////////////////////////////////////////
    // line geometry
    ////////////////////////////////////////

    localparam int NUM_SETS       = 128;
    localparam int NUM_WAYS       = 2;
    localparam int WORDS_PER_LINE = 8;
    // word 0 of a line sits in the lowest bits
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W;

    ////////////////////////////////////////
    // controller states and request kinds
    ////////////////////////////////////////

    // lookup takes the request, compare checks the tags,
    // writeback flushes a dirty victim, refill loads the line
    typedef enum logic [1:0] {
        ST_LOOKUP    = 2'd0,
        ST_COMPARE   = 2'd1,
        ST_WRITEBACK = 2'd2,
        ST_REFILL    = 2'd3
    } cache_state_e;

    // latched kind of the request in flight
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cpu_op_e;

endpackage

//--- verilog/dcache_tag_store.sv
`timescale 1ns/1ps

module dcache_tag_store
    import dcache_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [INDEX_W-1:0]  index_i,
    input  logic [TAG_W-1:0]    tag_i,
    input  logic                hit_write_i,
    input  logic                hit_way_sel_i,
    input  logic                lru_touch_i,
    input  logic                fill_en_i,
    input  logic                fill_way_i,
    input  logic                fill_dirty_i,
    output logic [NUM_WAYS-1:0] hit_way_o,
    output logic                victim_way_o,
    output logic                victim_dirty_o,
    output logic [TAG_W-1:0]    victim_tag_o
);

    ////////////////////////////////////////
    // arrays
    ////////////////////////////////////////

    logic [TAG_W-1:0]    tag_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
    logic [NUM_SETS-1:0] dirty_q [NUM_WAYS];
    // lru bit names the way to evict next
    logic [NUM_SETS-1:0] lru_q;

    // read registers valid one cycle after the index
    logic [TAG_W-1:0]    rd_tag [NUM_WAYS];
    logic [NUM_WAYS-1:0] rd_valid;
    logic [NUM_WAYS-1:0] rd_dirty;
    logic                rd_lru;

    // tag array and tag read registers
    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            tag_mem[fill_way_i][index_i] <= tag_i;
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            rd_tag[w] <= tag_mem[w][index_i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            lru_q    <= '0;
            rd_valid <= '0;
            rd_dirty <= '0;
            rd_lru   <= 1'b0;
        end else begin
            if (fill_en_i) begin
                valid_q[fill_way_i][index_i] <= 1'b1;
                dirty_q[fill_way_i][index_i] <= fill_dirty_i;
                lru_q[index_i]               <= ~fill_way_i;
            end else begin
                if (hit_write_i) begin
                    dirty_q[hit_way_sel_i][index_i] <= 1'b1;
                end
                if (lru_touch_i) begin
                    lru_q[index_i] <= ~hit_way_sel_i;
                end
            end
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_valid[w] <= valid_q[w][index_i];
                rd_dirty[w] <= dirty_q[w][index_i];
            end
            rd_lru <= lru_q[index_i];
        end
    end

    ////////////////////////////////////////
    // compare and victim
    ////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_way_o[w] = rd_valid[w] && (rd_tag[w] == tag_i);
        end
    end

    assign victim_way_o   = rd_lru;
    // only a valid line can need a write-back
    assign victim_dirty_o = rd_dirty[rd_lru] && rd_valid[rd_lru];
    assign victim_tag_o   = rd_tag[rd_lru];

    // a fill goes to the lru way so a tag lives in one way only
    a_one_way_hit: assert property (@(posedge clk) disable iff (rst)
        !(hit_way_o[0] && hit_way_o[1]));

endmodule

//--- verilog/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // cpu side
    input  logic              cpu_rreq_i,
    input  logic              cpu_wreq_i,
    input  logic [ADDR_W-1:0] virtual_addr_i,
    input  logic [WORD_W-1:0] cpu_wdata_i,
    input  logic [BYTE_SEL_W-1:0] cpu_wsel_i,
    output logic              hit_o,
    output logic              cpu_data_valid_o,
    output logic [WORD_W-1:0] cpu_data_o,
    output logic              cpu_stall_o,

    // memory side
    input  logic              mem_rvalid_i,
    input  logic [LINE_W-1:0] mem_rdata_i,
    input  logic              mem_bvalid_i,
    output logic              mem_ren_o,
    output logic [ADDR_W-1:0] mem_araddr_o,
    output logic              mem_wen_o,
    output logic [LINE_W-1:0] mem_wdata_o,
    output logic [ADDR_W-1:0] mem_awaddr_o
);

    // controller to stores
    logic [INDEX_W-1:0]    index;
    logic [TAG_W-1:0]      tag;
    logic [OFFSET_W-1:0]   word_sel;
    logic [WORD_W-1:0]     wdata;
    logic [BYTE_SEL_W-1:0] wsel;
    logic                  rd_way;
    logic                  hit_write;
    logic                  lru_touch;
    logic                  fill_en;
    logic                  fill_way;
    logic                  fill_dirty;

    // tag store to controller and data store
    logic [NUM_WAYS-1:0]   hit_way;
    logic                  victim_way;
    logic                  victim_dirty;
    logic [TAG_W-1:0]      victim_tag;

    dcache_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .cpu_rreq_i       (cpu_rreq_i),
        .cpu_wreq_i       (cpu_wreq_i),
        .virtual_addr_i   (virtual_addr_i),
        .cpu_wdata_i      (cpu_wdata_i),
        .cpu_wsel_i       (cpu_wsel_i),
        .mem_rvalid_i     (mem_rvalid_i),
        .mem_bvalid_i     (mem_bvalid_i),
        .hit_way_i        (hit_way),
        .victim_way_i     (victim_way),
        .victim_dirty_i   (victim_dirty),
        .victim_tag_i     (victim_tag),
        .index_o          (index),
        .tag_o            (tag),
        .word_sel_o       (word_sel),
        .wdata_o          (wdata),
        .wsel_o           (wsel),
        .rd_way_o         (rd_way),
        .hit_write_o      (hit_write),
        .lru_touch_o      (lru_touch),
        .fill_en_o        (fill_en),
        .fill_way_o       (fill_way),
        .fill_dirty_o     (fill_dirty),
        .hit_o            (hit_o),
        .cpu_data_valid_o (cpu_data_valid_o),
        .cpu_stall_o      (cpu_stall_o),
        .mem_ren_o        (mem_ren_o),
        .mem_araddr_o     (mem_araddr_o),
        .mem_wen_o        (mem_wen_o),
        .mem_awaddr_o     (mem_awaddr_o)
    );

    dcache_tag_store u_tag_store (
        .clk            (clk),
        .rst            (rst),
        .index_i        (index),
        .tag_i          (tag),
        .hit_write_i    (hit_write),
        .hit_way_sel_i  (rd_way),
        .lru_touch_i    (lru_touch),
        .fill_en_i      (fill_en),
        .fill_way_i     (fill_way),
        .fill_dirty_i   (fill_dirty),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    // a write miss is the only fill that merges cpu bytes
    dcache_data_store u_data_store (
        .clk           (clk),
        .index_i       (index),
        .word_sel_i    (word_sel),
        .rd_way_i      (rd_way),
        .hit_write_i   (hit_write),
        .wsel_i        (wsel),
        .wdata_i       (wdata),
        .fill_en_i     (fill_en),
        .fill_way_i    (fill_way),
        .fill_merge_i  (fill_dirty),
        .fill_line_i   (mem_rdata_i),
        .victim_way_i  (victim_way),
        .rdata_word_o  (cpu_data_o),
        .victim_line_o (mem_wdata_o)
    );

endmodule
